// ==== project.f ====
+incdir+test
source/book_types_pkg.sv
source/book_cfg_pkg.sv
source/book_match.sv
source/book_shift_ctrl.sv
source/book_entry_mux.sv
source/book_state_regs.sv
source/book_notify.sv
source/book_top.sv
test/tb_book.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the order book testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_book -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_book > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

// ==== test/tb_book_vectors.svh ====
// Expected values assume a bid table of 8 levels and keys that are never added twice
`ifndef TB_BOOK_VECTORS_SVH
`define TB_BOOK_VECTORS_SVH

localparam int ROWS_N = 18;

// Each row gives the command, key and volume, then the expected list size and notify flag,
// key and volume. The two lines after it list the expected keys and volumes from the head
task automatic load_vectors();
  // Sorted insertion, only new heads notify
  set_row(0, CMD_ADD, 50, 500, 1, 1, 50, 500);
  row_keys[0] = '{50, 0, 0, 0, 0, 0, 0, 0};
  row_vols[0] = '{500, 0, 0, 0, 0, 0, 0, 0};
  set_row(1, CMD_ADD, 70, 700, 2, 1, 70, 700);
  row_keys[1] = '{70, 50, 0, 0, 0, 0, 0, 0};
  row_vols[1] = '{700, 500, 0, 0, 0, 0, 0, 0};
  set_row(2, CMD_ADD, 60, 600, 3, 0, 0, 0);
  row_keys[2] = '{70, 60, 50, 0, 0, 0, 0, 0};
  row_vols[2] = '{700, 600, 500, 0, 0, 0, 0, 0};
  set_row(3, CMD_ADD, 40, 400, 4, 0, 0, 0);
  row_keys[3] = '{70, 60, 50, 40, 0, 0, 0, 0};
  row_vols[3] = '{700, 600, 500, 400, 0, 0, 0, 0};
  set_row(4, CMD_ADD, 30, 300, 5, 0, 0, 0);
  row_keys[4] = '{70, 60, 50, 40, 30, 0, 0, 0};
  row_vols[4] = '{700, 600, 500, 400, 300, 0, 0, 0};
  set_row(5, CMD_ADD, 20, 200, 6, 0, 0, 0);
  row_keys[5] = '{70, 60, 50, 40, 30, 20, 0, 0};
  row_vols[5] = '{700, 600, 500, 400, 300, 200, 0, 0};
  set_row(6, CMD_ADD, 10, 100, 7, 0, 0, 0);
  row_keys[6] = '{70, 60, 50, 40, 30, 20, 10, 0};
  row_vols[6] = '{700, 600, 500, 400, 300, 200, 100, 0};
  set_row(7, CMD_ADD, 65, 650, 8, 0, 0, 0);
  row_keys[7] = '{70, 65, 60, 50, 40, 30, 20, 10};
  row_vols[7] = '{700, 650, 600, 500, 400, 300, 200, 100};
  // Full table, key 10 falls off the end
  set_row(8, CMD_ADD, 90, 900, 8, 1, 90, 900);
  row_keys[8] = '{90, 70, 65, 60, 50, 40, 30, 20};
  row_vols[8] = '{900, 700, 650, 600, 500, 400, 300, 200};
  // Worse than every level, so nothing enters
  set_row(9, CMD_ADD, 5, 55, 8, 0, 0, 0);
  row_keys[9] = '{90, 70, 65, 60, 50, 40, 30, 20};
  row_vols[9] = '{900, 700, 650, 600, 500, 400, 300, 200};
  // Deleting the head reports the removed volume
  set_row(10, CMD_DELETE, 90, 0, 7, 1, 90, 900);
  row_keys[10] = '{70, 65, 60, 50, 40, 30, 20, 0};
  row_vols[10] = '{700, 650, 600, 500, 400, 300, 200, 0};
  set_row(11, CMD_DELETE, 99, 0, 7, 0, 0, 0);
  row_keys[11] = '{70, 65, 60, 50, 40, 30, 20, 0};
  row_vols[11] = '{700, 650, 600, 500, 400, 300, 200, 0};
  set_row(12, CMD_REPLACE, 70, 777, 7, 1, 70, 777);
  row_keys[12] = '{70, 65, 60, 50, 40, 30, 20, 0};
  row_vols[12] = '{777, 650, 600, 500, 400, 300, 200, 0};
  set_row(13, CMD_REPLACE, 60, 666, 7, 0, 0, 0);
  row_keys[13] = '{70, 65, 60, 50, 40, 30, 20, 0};
  row_vols[13] = '{777, 650, 666, 500, 400, 300, 200, 0};
  set_row(14, CMD_REPLACE, 20, 222, 7, 0, 0, 0);
  row_keys[14] = '{70, 65, 60, 50, 40, 30, 20, 0};
  row_vols[14] = '{777, 650, 666, 500, 400, 300, 222, 0};
  set_row(15, CMD_CLEAR, 0, 0, 0, 1, 0, 0);
  row_keys[15] = '{0, 0, 0, 0, 0, 0, 0, 0};
  row_vols[15] = '{0, 0, 0, 0, 0, 0, 0, 0};
  set_row(16, CMD_CLEAR, 0, 0, 0, 0, 0, 0);
  row_keys[16] = '{0, 0, 0, 0, 0, 0, 0, 0};
  row_vols[16] = '{0, 0, 0, 0, 0, 0, 0, 0};
  set_row(17, CMD_ADD, 42, 420, 1, 1, 42, 420);
  row_keys[17] = '{42, 0, 0, 0, 0, 0, 0, 0};
  row_vols[17] = '{420, 0, 0, 0, 0, 0, 0, 0};
endtask

`endif

// ==== test/tb_book.sv ====
// Drives one bid-side book built with the default 8 levels and stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_book import book_types_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 5;
  localparam int ROWS_MAX = 32;
  localparam int LEVELS = 8;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          cmd_vld;
  cmd_t          cmd;
  key_t          key;
  volume_t       volume;
  logic [7:0]    vld;
  key_t [7:0]    keys;
  volume_t [7:0] volumes;
  listsize_t     listsize;
  logic          notify_vld;
  key_t          notify_key;
  volume_t       notify_volume;

  // Stimulus columns and expected columns, filled from the included table
  cmd_t row_cmd [ROWS_MAX];
  int   row_key [ROWS_MAX];
  int   row_vol [ROWS_MAX];
  int   row_size [ROWS_MAX];
  int   row_keys [ROWS_MAX][LEVELS];
  int   row_vols [ROWS_MAX][LEVELS];
  int   row_ntf [ROWS_MAX];
  int   row_ntf_key [ROWS_MAX];
  int   row_ntf_vol [ROWS_MAX];

  book_top DUT (
    .i_clk(clk), .i_rst_n(rst_n), .i_cmd_vld(cmd_vld), .i_cmd(cmd),
    .i_key(key), .i_volume(volume),
    .o_vld(vld), .o_keys(keys), .o_volumes(volumes), .o_listsize(listsize),
    .o_notify_vld(notify_vld), .o_notify_key(notify_key),
    .o_notify_volume(notify_volume)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic set_row(input int idx, input cmd_t c, input int k, input int v,
                         input int size, input int ntf, input int ntf_k, input int ntf_v);
    row_cmd[idx] = c;
    row_key[idx] = k;
    row_vol[idx] = v;
    row_size[idx] = size;
    row_ntf[idx] = ntf;
    row_ntf_key[idx] = ntf_k;
    row_ntf_vol[idx] = ntf_v;
  endtask

  `include "tb_book_vectors.svh"

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_value(input string name, input int got, input int exp);
    assert (got == exp)
      else begin
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        stop_with_failure();
      end
  endtask

  // One command strobe, held for exactly one cycle by the loop
  task automatic drive_row(input int r);
    cmd_vld = 1'b1;
    cmd = row_cmd[r];
    key = key_t'(row_key[r]);
    volume = volume_t'(row_vol[r]);
  endtask

  task automatic verify_row(input int r);
    compare_value("o_listsize", int'(listsize), row_size[r]);
    // Valid levels form a run from the head as long as the list size
    compare_value("o_vld", int'(vld), (1 << row_size[r]) - 1);
    // Keys and volumes only carry meaning where the level is valid
    for (int i = 0; i < row_size[r]; i++) begin
      compare_value($sformatf("o_keys[%0d]", i), int'(keys[i]), row_keys[r][i]);
      compare_value($sformatf("o_volumes[%0d]", i), int'(volumes[i]), row_vols[r][i]);
    end
    compare_value("o_notify_vld", int'(notify_vld), row_ntf[r]);
    if (row_ntf[r] != 0) begin
      compare_value("o_notify_key", int'(notify_key), row_ntf_key[r]);
      compare_value("o_notify_volume", int'(notify_volume), row_ntf_vol[r]);
    end
  endtask

  // Bound from the table length plus reset and idle cycles
  initial begin
    #((ROWS_N + 20) * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    stop_with_failure();
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n = 1'b0;
    cmd_vld = 1'b0;
    cmd = CMD_CLEAR;
    key = '0;
    volume = '0;
    if (ROWS_N > ROWS_MAX) begin
      $display("The vector table has more rows than the testbench can store");
      stop_with_failure();
    end
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare_value("o_vld", int'(vld), 0);
    compare_value("o_listsize", int'(listsize), 0);
    compare_value("o_notify_vld", int'(notify_vld), 0);
    // An idle cycle after reset must not disturb the empty table
    @(posedge clk);
    #1;
    compare_value("o_vld", int'(vld), 0);
    compare_value("o_notify_vld", int'(notify_vld), 0);
    // Back to back commands, each checked one edge after its strobe
    for (int r = 0; r < ROWS_N; r++) begin
      drive_row(r);
      @(posedge clk);
      #1;
      verify_row(r);
    end
    cmd_vld = 1'b0;
    @(posedge clk);
    #1;
    // Notify lasts a single cycle and the idle cycle keeps the size
    compare_value("o_notify_vld", int'(notify_vld), 0);
    compare_value("o_listsize", int'(listsize), row_size[ROWS_N-1]);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/book_top.sv ====
// One table side per instance and commands are strobes with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module book_top import book_types_pkg::*, book_cfg_pkg::*; #(
  parameter int ENTRIES_N = DEF_ENTRIES_N,
  parameter bit IS_BID = DEF_IS_BID
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_cmd_vld,
  input  cmd_t                     i_cmd,
  input  key_t                     i_key,
  input  volume_t                  i_volume,
  output logic [ENTRIES_N-1:0]     o_vld,
  output key_t [ENTRIES_N-1:0]     o_keys,
  output volume_t [ENTRIES_N-1:0]  o_volumes,
  output listsize_t                o_listsize,
  output logic                     o_notify_vld,
  output key_t                     o_notify_key,
  output volume_t                  o_notify_volume
);

  logic [ENTRIES_N-1:0]     match_sel;
  logic                     hit;
  logic                     full;
  logic [ENTRIES_N-1:0]     insert_sel;
  volume_t                  match_volume;
  logic [ENTRIES_N-1:0]     vld_nxt;
  logic [ENTRIES_N-1:0]     take_right;
  logic [ENTRIES_N-1:0]     take_left;
  logic [ENTRIES_N-1:0]     ins_key;
  logic [ENTRIES_N-1:0]     ins_vol;
  logic                     size_inc;
  logic                     size_dec;
  logic                     size_clr;
  key_t [ENTRIES_N-1:0]     keys_nxt;
  volume_t [ENTRIES_N-1:0]  volumes_nxt;

  // Register outputs feed the update logic and the top-level ports alike
  book_match #(.ENTRIES_N(ENTRIES_N), .IS_BID(IS_BID)) u_match (
    .i_key(i_key), .i_vld(o_vld), .i_keys(o_keys), .i_volumes(o_volumes),
    .o_match_sel(match_sel), .o_hit(hit), .o_full(full),
    .o_insert_sel(insert_sel), .o_match_volume(match_volume)
  );

  book_shift_ctrl #(.ENTRIES_N(ENTRIES_N)) u_shift_ctrl (
    .i_cmd_vld(i_cmd_vld), .i_cmd(i_cmd), .i_vld(o_vld),
    .i_match_sel(match_sel), .i_hit(hit), .i_full(full), .i_insert_sel(insert_sel),
    .o_vld_nxt(vld_nxt), .o_take_right(take_right), .o_take_left(take_left),
    .o_ins_key(ins_key), .o_ins_vol(ins_vol),
    .o_size_inc(size_inc), .o_size_dec(size_dec), .o_size_clr(size_clr)
  );

  book_entry_mux #(.ENTRIES_N(ENTRIES_N)) u_entry_mux (
    .i_key(i_key), .i_volume(i_volume), .i_keys(o_keys), .i_volumes(o_volumes),
    .i_take_right(take_right), .i_take_left(take_left),
    .i_ins_key(ins_key), .i_ins_vol(ins_vol),
    .o_keys_nxt(keys_nxt), .o_volumes_nxt(volumes_nxt)
  );

  book_state_regs #(.ENTRIES_N(ENTRIES_N)) u_state_regs (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_vld_nxt(vld_nxt), .i_keys_nxt(keys_nxt), .i_volumes_nxt(volumes_nxt),
    .i_size_inc(size_inc), .i_size_dec(size_dec), .i_size_clr(size_clr),
    .o_vld(o_vld), .o_keys(o_keys), .o_volumes(o_volumes), .o_listsize(o_listsize)
  );

  // Entry 0 holds the best price
  book_notify #(.ENTRIES_N(ENTRIES_N)) u_notify (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_cmd_vld(i_cmd_vld), .i_cmd(i_cmd), .i_key(i_key), .i_volume(i_volume),
    .i_head_vld(o_vld[0]), .i_match_sel(match_sel), .i_insert_sel(insert_sel),
    .i_match_volume(match_volume),
    .o_notify_vld(o_notify_vld), .o_notify_key(o_notify_key),
    .o_notify_volume(o_notify_volume)
  );

endmodule

`default_nettype wire

// ==== source/book_notify.sv ====
// Notify is valid for one cycle only and key and volume hold the last report in between
`timescale 1ns/1ps
`default_nettype none

module book_notify import book_types_pkg::*; #(
  parameter int ENTRIES_N = 8
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_cmd_vld,
  input  cmd_t                  i_cmd,
  input  key_t                  i_key,
  input  volume_t               i_volume,
  input  logic                  i_head_vld,
  input  logic [ENTRIES_N-1:0]  i_match_sel,
  input  logic [ENTRIES_N-1:0]  i_insert_sel,
  input  volume_t               i_match_volume,
  output logic                  o_notify_vld,
  output key_t                  o_notify_key,
  output volume_t               o_notify_volume
);

  logic    head_change;
  volume_t volume_nxt;

  // Any command that touches entry 0 changes the best price
  // A CLEAR on an empty table leaves the head untouched
  always_comb begin
    head_change = 1'b0;
    volume_nxt = '0;
    if (i_cmd_vld) begin
      case (i_cmd)
        CMD_CLEAR: head_change = i_head_vld;
        CMD_ADD: begin
          head_change = i_insert_sel[0];
          volume_nxt = i_volume;
        end
        CMD_DELETE: begin
          head_change = i_match_sel[0];
          // Report what was taken off the head
          volume_nxt = i_match_volume;
        end
        CMD_REPLACE: begin
          head_change = i_match_sel[0];
          volume_nxt = i_volume;
        end
        default: head_change = 1'b0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_notify_vld <= 1'b0;
    end else begin
      o_notify_vld <= head_change;
    end
  end

  // The key reported is always the command key
  always_ff @(posedge i_clk) begin
    if (head_change) begin
      o_notify_key <= i_key;
      o_notify_volume <= volume_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/book_state_regs.sv ====
// Loads every cycle and relies on the update logic to feed back the current state when idle
`timescale 1ns/1ps
`default_nettype none

module book_state_regs import book_types_pkg::*; #(
  parameter int ENTRIES_N = 8
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic [ENTRIES_N-1:0]     i_vld_nxt,
  input  key_t [ENTRIES_N-1:0]     i_keys_nxt,
  input  volume_t [ENTRIES_N-1:0]  i_volumes_nxt,
  input  logic                     i_size_inc,
  input  logic                     i_size_dec,
  input  logic                     i_size_clr,
  output logic [ENTRIES_N-1:0]     o_vld,
  output key_t [ENTRIES_N-1:0]     o_keys,
  output volume_t [ENTRIES_N-1:0]  o_volumes,
  output listsize_t                o_listsize
);

  // Validity and the size counter are control state
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_vld <= '0;
      o_listsize <= '0;
    end else begin
      o_vld <= i_vld_nxt;
      if (i_size_clr) begin
        o_listsize <= '0;
      end else if (i_size_inc) begin
        o_listsize <= o_listsize + 1'b1;
      end else if (i_size_dec) begin
        o_listsize <= o_listsize - 1'b1;
      end
    end
  end

  // Keys and volumes only mean something where the matching valid bit is set
  always_ff @(posedge i_clk) begin
    o_keys <= i_keys_nxt;
    o_volumes <= i_volumes_nxt;
  end

  // Valid levels always form an unbroken run starting at the head
  a_vld_contig: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((o_vld & (o_vld + 1'b1)) == '0))
    else $error("book_state_regs: validity has a hole");

  // The counter tracks the validity vector built by the shift logic
  a_size_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_listsize == listsize_t'($countones(o_vld))))
    else $error("book_state_regs: list size out of step with validity");

  a_inc_dec: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_size_inc && i_size_dec))
    else $error("book_state_regs: size increment and decrement together");

endmodule

`default_nettype wire

// ==== source/book_entry_mux.sv ====
// Combinational only and assumes at most one of the select masks is set per entry
`timescale 1ns/1ps
`default_nettype none

module book_entry_mux import book_types_pkg::*; #(
  parameter int ENTRIES_N = 8
) (
  input  key_t                     i_key,
  input  volume_t                  i_volume,
  input  key_t [ENTRIES_N-1:0]     i_keys,
  input  volume_t [ENTRIES_N-1:0]  i_volumes,
  input  logic [ENTRIES_N-1:0]     i_take_right,
  input  logic [ENTRIES_N-1:0]     i_take_left,
  input  logic [ENTRIES_N-1:0]     i_ins_key,
  input  logic [ENTRIES_N-1:0]     i_ins_vol,
  output key_t [ENTRIES_N-1:0]     o_keys_nxt,
  output volume_t [ENTRIES_N-1:0]  o_volumes_nxt
);

  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_entry
    key_t    key_pushed;
    volume_t vol_pushed;
    key_t    key_pulled;
    volume_t vol_pulled;

    // An add push takes the neighbour below
    // The head has no neighbour below and is never pushed into
    if (i > 0) begin : g_lo
      assign key_pushed = i_take_right[i] ? i_keys[i-1] : i_keys[i];
      assign vol_pushed = i_take_right[i] ? i_volumes[i-1] : i_volumes[i];
    end else begin : g_head
      assign key_pushed = i_keys[i];
      assign vol_pushed = i_volumes[i];
    end

    // A delete pull takes the neighbour above and wins over a push
    // The top entry has no neighbour above, its validity is dropped by the shift
    if (i < ENTRIES_N - 1) begin : g_hi
      assign key_pulled = i_take_left[i] ? i_keys[i+1] : key_pushed;
      assign vol_pulled = i_take_left[i] ? i_volumes[i+1] : vol_pushed;
    end else begin : g_top
      assign key_pulled = key_pushed;
      assign vol_pulled = vol_pushed;
    end

    // Insert wins over both shifts
    assign o_keys_nxt[i] = i_ins_key[i] ? i_key : key_pulled;

    // REPLACE raises only the volume insert so the key is held
    assign o_volumes_nxt[i] = i_ins_vol[i] ? i_volume : vol_pulled;
  end

endmodule

`default_nettype wire

// ==== source/book_shift_ctrl.sv ====
// Combinational only and expects the current validity vector to be contiguous from entry 0
`timescale 1ns/1ps
`default_nettype none

module book_shift_ctrl import book_types_pkg::*; #(
  parameter int ENTRIES_N = 8
) (
  input  logic                  i_cmd_vld,
  input  cmd_t                  i_cmd,
  input  logic [ENTRIES_N-1:0]  i_vld,
  input  logic [ENTRIES_N-1:0]  i_match_sel,
  input  logic                  i_hit,
  input  logic                  i_full,
  input  logic [ENTRIES_N-1:0]  i_insert_sel,
  output logic [ENTRIES_N-1:0]  o_vld_nxt,
  output logic [ENTRIES_N-1:0]  o_take_right,
  output logic [ENTRIES_N-1:0]  o_take_left,
  output logic [ENTRIES_N-1:0]  o_ins_key,
  output logic [ENTRIES_N-1:0]  o_ins_vol,
  output logic                  o_size_inc,
  output logic                  o_size_dec,
  output logic                  o_size_clr
);

  logic                 op_clr;
  logic                 op_add;
  logic                 op_del;
  logic                 op_rep;
  logic [ENTRIES_N-1:0] add_upper;
  logic [ENTRIES_N-1:0] add_shift;
  logic [ENTRIES_N-1:0] add_vld;
  logic [ENTRIES_N-1:0] del_upper;
  logic [ENTRIES_N-1:0] del_shift;
  logic [ENTRIES_N-1:0] del_vld;

  // Every decoded operation is qualified by the strobe
  assign op_clr = i_cmd_vld && (i_cmd == CMD_CLEAR);
  assign op_add = i_cmd_vld && (i_cmd == CMD_ADD);
  assign op_del = i_cmd_vld && (i_cmd == CMD_DELETE);
  assign op_rep = i_cmd_vld && (i_cmd == CMD_REPLACE);

  // Entries at and above the insertion slot move one place up
  // With no slot the subtraction wraps and the mask comes out empty
  assign add_upper = ~(i_insert_sel - 1'b1);
  // Anything shifted past the top entry falls off the table
  assign add_shift = (i_vld & add_upper) << 1;
  assign add_vld = i_vld | add_shift | i_insert_sel;

  // Entries at and above the matched level move one place toward the head
  // A miss leaves this mask empty so the validity is unchanged
  assign del_upper = ~(i_match_sel - 1'b1);
  assign del_shift = (i_vld & del_upper) >> 1;
  assign del_vld = (i_vld & ~del_upper) | del_shift;

  // REPLACE and an idle cycle both keep the current validity
  always_comb begin
    o_vld_nxt = i_vld;
    if (op_clr) begin
      o_vld_nxt = '0;
    end else if (op_add) begin
      o_vld_nxt = add_vld;
    end else if (op_del) begin
      o_vld_nxt = del_vld;
    end
  end

  // Take from entry i-1 on ADD, from entry i+1 on DELETE
  assign o_take_right = {ENTRIES_N{op_add}} & add_shift;
  assign o_take_left = {ENTRIES_N{op_del}} & del_upper;
  assign o_ins_key = {ENTRIES_N{op_add}} & i_insert_sel;
  assign o_ins_vol = ({ENTRIES_N{op_add}} & i_insert_sel) |
                     ({ENTRIES_N{op_rep}} & i_match_sel);

  // A non-full table always takes the new level somewhere
  assign o_size_inc = op_add && !i_full;
  assign o_size_dec = op_del && i_hit;
  assign o_size_clr = op_clr;

endmodule

`default_nettype wire

// ==== source/book_match.sv ====
// Combinational only and assumes the table never holds the same key twice
`timescale 1ns/1ps
`default_nettype none

module book_match import book_types_pkg::*; #(
  parameter int ENTRIES_N = 8,
  parameter bit IS_BID = 1'b1
) (
  input  key_t                      i_key,
  input  logic [ENTRIES_N-1:0]      i_vld,
  input  key_t [ENTRIES_N-1:0]      i_keys,
  input  volume_t [ENTRIES_N-1:0]   i_volumes,
  output logic [ENTRIES_N-1:0]      o_match_sel,
  output logic                      o_hit,
  output logic                      o_full,
  output logic [ENTRIES_N-1:0]      o_insert_sel,
  output volume_t                   o_match_volume
);

  logic [ENTRIES_N-1:0] match_sel;
  logic [ENTRIES_N-1:0] keep_mask;

  // Equality and ordering against every valid entry
  // Invalid entries never match and never count as better
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      match_sel[i] = i_vld[i] && (i_keys[i] == i_key);
      keep_mask[i] = i_vld[i] && ((i_keys[i] == i_key) ||
                     (IS_BID ? (i_keys[i] > i_key) : (i_keys[i] < i_key)));
    end
  end

  // The table is sorted so keep_mask is a run of ones from the head
  // Its lowest zero is the insertion slot, and an all-ones mask gives no slot
  assign o_insert_sel = ~keep_mask & (keep_mask + 1'b1);

  assign o_match_sel = match_sel;
  assign o_hit = |match_sel;
  assign o_full = &i_vld;

  // Volume of the matching level, zero on a miss
  always_comb begin
    o_match_volume = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (match_sel[i]) begin
        o_match_volume = o_match_volume | i_volumes[i];
      end
    end
  end

  // Two hits mean an ADD was given a key already in the table
  always_comb begin
    assert final ($isunknown(match_sel) || $onehot0(match_sel))
      else $error("book_match: duplicate key found in table");
  end

endmodule

`default_nettype wire

// ==== source/book_cfg_pkg.sv ====
// Defaults only apply through book_top and DEF_ENTRIES_N must stay below 2**LISTSIZE_W
`default_nettype none

package book_cfg_pkg;

  // Number of price levels kept in the table
  localparam int DEF_ENTRIES_N = 8;

  // One selects the bid side with the highest key at the head
  // Zero selects the ask side with the lowest key at the head
  localparam bit DEF_IS_BID = 1'b1;

endpackage

`default_nettype wire

// ==== source/book_types_pkg.sv ====
// Key, volume and list-size widths are fixed here and LISTSIZE_W must hold ENTRIES_N itself
`default_nettype none

package book_types_pkg;

  // Price keys and volumes are plain unsigned integers
  localparam int KEY_BITS = 16;
  localparam int VOLUME_BITS = 16;

  // Wide enough to count a full table of up to 15 levels
  localparam int LISTSIZE_W = 4;

  typedef logic [KEY_BITS-1:0] key_t;
  typedef logic [VOLUME_BITS-1:0] volume_t;
  typedef logic [LISTSIZE_W-1:0] listsize_t;

  // Command code carried alongside the command strobe
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

endpackage

`default_nettype wire
